// File: req_buffer_pkg.sv
`default_nettype none

// Types shared by the request buffer RTL and its testbench
package req_buffer_pkg;

    // Width of one request payload as it travels on the memory channel
    localparam int REQ_DATA_BITS = 32;

    // Request payload that travels unchanged from producer to the outgoing channel
    typedef logic [REQ_DATA_BITS-1:0] t_req_data;

    // Source stream of a request as tagged on the outgoing channel
    typedef enum logic
    {
        CHAN_RD = 1'b0,
        CHAN_WR = 1'b1
    } t_chan;

endpackage

`default_nettype wire

// File: req_fifo_lutram.sv
`timescale 1ns/1ns
`default_nettype none

// FIFO with N_ENTRIES slots held in distributed RAM
// almost_full rises when THRESHOLD or fewer slots are free, so a producer
// that watches it has time to stop before the FIFO overflows
module req_fifo_lutram
#(
    parameter int N_ENTRIES = 8,
    parameter int THRESHOLD = 2
)
(
    input  logic                     clk,
    input  logic                     resetb,

    // Producer side
    input  req_buffer_pkg::t_req_data enq_data,
    input  logic                     enq_en,
    output logic                     not_full,
    output logic                     almost_full,

    // Consumer side
    output req_buffer_pkg::t_req_data first,
    input  logic                     deq_en,
    output logic                     not_empty
);

    import req_buffer_pkg::*;

    // Slot index into the storage array
    typedef logic [$clog2(N_ENTRIES)-1:0] t_idx;

    // Live-entry count with room for both 0 and N_ENTRIES
    typedef logic [$clog2(N_ENTRIES+1)-1:0] t_cnt;

    // Storage array
    // Written on one port and read asynchronously so it maps onto LUT RAM
    // rather than block RAM or flops
    t_req_data data [0:N_ENTRIES-1];

    t_idx wr_idx;
    t_idx rd_idx;

    t_cnt valid_cnt;
    t_cnt valid_cnt_next;

    // Head entry is read straight from the array at the read pointer
    assign first = data[rd_idx];

    // Payload write into the slot at the write pointer
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            data[wr_idx] <= enq_data;
        end
    end

    // Write pointer steps on every enqueue and wraps at the last slot
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            wr_idx <= '0;
        end
        else if (enq_en)
        begin
            wr_idx <= (wr_idx == t_idx'(N_ENTRIES - 1)) ? '0 : wr_idx + t_idx'(1);
        end
    end

    // Read pointer steps on every dequeue and wraps the same way
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rd_idx <= '0;
        end
        else if (deq_en)
        begin
            rd_idx <= (rd_idx == t_idx'(N_ENTRIES - 1)) ? '0 : rd_idx + t_idx'(1);
        end
    end

    // Next count of live entries
    // An enqueue and a dequeue in the same cycle cancel out
    always_comb
    begin
        valid_cnt_next = valid_cnt;

        if (enq_en && !deq_en)
        begin
            valid_cnt_next = valid_cnt + t_cnt'(1);
        end
        else if (deq_en && !enq_en)
        begin
            valid_cnt_next = valid_cnt - t_cnt'(1);
        end
    end

    // Count and flags
    // Flags are computed from the next count so that they are registered yet
    // still reflect an enqueue or dequeue right after the edge that made it
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            valid_cnt   <= '0;
            not_full    <= 1'b1;
            almost_full <= 1'b0;
            not_empty   <= 1'b0;
        end
        else
        begin
            valid_cnt   <= valid_cnt_next;
            not_full    <= (valid_cnt_next != t_cnt'(N_ENTRIES));
            almost_full <= (valid_cnt_next >= t_cnt'(N_ENTRIES - THRESHOLD));
            not_empty   <= (valid_cnt_next != '0);
        end
    end

endmodule

`default_nettype wire

// File: req_issue_arb.sv
`timescale 1ns/1ns
`default_nettype none

// Round-robin issuer for two request FIFOs
// Each cycle it picks at most one non-empty FIFO, pops its head and puts that
// entry on the outgoing channel one edge later
module req_issue_arb
(
    input  logic                      clk,
    input  logic                      resetb,

    // Read-request FIFO drain side
    input  req_buffer_pkg::t_req_data rd_first,
    input  logic                      rd_not_empty,
    output logic                      rd_deq_en,

    // Write-request FIFO drain side
    input  req_buffer_pkg::t_req_data wr_first,
    input  logic                      wr_not_empty,
    output logic                      wr_deq_en,

    // Outgoing request channel
    input  logic                      out_almost_full,
    output logic                      out_valid,
    output req_buffer_pkg::t_req_data out_data,
    output req_buffer_pkg::t_chan     out_chan
);

    import req_buffer_pkg::*;

    // Stream that won the most recent grant
    t_chan last_grant;

    // Round-robin choice before back-pressure is applied
    logic rd_pick;
    logic wr_pick;

    // The request that actually leaves a FIFO this cycle
    logic      issue;
    t_chan     sel_chan;
    t_req_data sel_data;

    // Read wins if it is the only one waiting, or if both wait and write
    // had the last turn
    // Write wins whenever it waits and read does not win
    always_comb
    begin
        rd_pick = rd_not_empty && (!wr_not_empty || (last_grant == CHAN_WR));
        wr_pick = wr_not_empty && !rd_pick;
    end

    // Nothing leaves either FIFO while the consumer signals almost full
    // At most one strobe is high, since rd_pick and wr_pick exclude each other
    assign rd_deq_en = rd_pick && !out_almost_full;
    assign wr_deq_en = wr_pick && !out_almost_full;

    assign issue = rd_deq_en || wr_deq_en;

    // Steer the granted head entry and its stream tag toward the output
    always_comb
    begin
        if (wr_deq_en)
        begin
            sel_chan = CHAN_WR;
            sel_data = wr_first;
        end
        else
        begin
            sel_chan = CHAN_RD;
            sel_data = rd_first;
        end
    end

    // Grant history
    // Starting from CHAN_WR hands the first contested grant to the read stream
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            last_grant <= CHAN_WR;
        end
        else if (issue)
        begin
            last_grant <= sel_chan;
        end
    end

    // Output valid is one cycle per dequeue, so the request is on the channel
    // for exactly one cycle
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= issue;
        end
    end

    // Payload and tag of the outgoing request
    // Only meaningful while out_valid is high
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            out_data <= sel_data;
            out_chan <= sel_chan;
        end
    end

endmodule

`default_nettype wire

// File: req_buffer_top.sv
`timescale 1ns/1ns
`default_nettype none

// Request buffer in front of a memory channel
// Read and write requests queue in separate FIFOs and are merged in
// round-robin order onto one outgoing channel
module req_buffer_top
#(
    // Depth of each stream FIFO
    parameter int N_ENTRIES = 8,
    // Free-slot count at or below which a producer sees almost_full
    parameter int THRESHOLD = 2
)
(
    input  logic                      clk,
    input  logic                      resetb,

    // Read-request producer
    input  req_buffer_pkg::t_req_data rd_enq_data,
    input  logic                      rd_enq_en,
    output logic                      rd_not_full,
    output logic                      rd_almost_full,

    // Write-request producer
    input  req_buffer_pkg::t_req_data wr_enq_data,
    input  logic                      wr_enq_en,
    output logic                      wr_not_full,
    output logic                      wr_almost_full,

    // Outgoing request channel
    input  logic                      out_almost_full,
    output logic                      out_valid,
    output req_buffer_pkg::t_req_data out_data,
    output req_buffer_pkg::t_chan     out_chan
);

    import req_buffer_pkg::*;

    // Drain side of the read FIFO
    t_req_data rd_first;
    logic      rd_not_empty;
    logic      rd_deq_en;

    // Drain side of the write FIFO
    t_req_data wr_first;
    logic      wr_not_empty;
    logic      wr_deq_en;

    // Read stream queue
    req_fifo_lutram
    #(
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    )
    rd_fifo
    (
        .clk         (clk),
        .resetb      (resetb),
        .enq_data    (rd_enq_data),
        .enq_en      (rd_enq_en),
        .not_full    (rd_not_full),
        .almost_full (rd_almost_full),
        .first       (rd_first),
        .deq_en      (rd_deq_en),
        .not_empty   (rd_not_empty)
    );

    // Write stream queue with the same depth and warning level as the read side
    req_fifo_lutram
    #(
        .N_ENTRIES   (N_ENTRIES),
        .THRESHOLD   (THRESHOLD)
    )
    wr_fifo
    (
        .clk         (clk),
        .resetb      (resetb),
        .enq_data    (wr_enq_data),
        .enq_en      (wr_enq_en),
        .not_full    (wr_not_full),
        .almost_full (wr_almost_full),
        .first       (wr_first),
        .deq_en      (wr_deq_en),
        .not_empty   (wr_not_empty)
    );

    // Merge both queues onto the outgoing channel
    req_issue_arb req_issue_arb_inst
    (
        .clk             (clk),
        .resetb          (resetb),
        .rd_first        (rd_first),
        .rd_not_empty    (rd_not_empty),
        .rd_deq_en       (rd_deq_en),
        .wr_first        (wr_first),
        .wr_not_empty    (wr_not_empty),
        .wr_deq_en       (wr_deq_en),
        .out_almost_full (out_almost_full),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_chan        (out_chan)
    );

endmodule

`default_nettype wire

// File: req_buffer_tb.sv
`timescale 1ns/1ns
`default_nettype none

// Directed testbench for the request buffer
// Inputs change on the falling edge and outputs are sampled there too, so every
// sample sees values that settled after the preceding rising edge
module req_buffer_tb;

    import req_buffer_pkg::*;

    localparam int N_ENTRIES = 8;
    localparam int THRESHOLD = 2;

    logic      clk;
    logic      resetb;
    t_req_data rd_enq_data;
    logic      rd_enq_en;
    logic      rd_not_full;
    logic      rd_almost_full;
    t_req_data wr_enq_data;
    logic      wr_enq_en;
    logic      wr_not_full;
    logic      wr_almost_full;
    logic      out_almost_full;
    logic      out_valid;
    t_req_data out_data;
    t_chan     out_chan;

    // Requests accepted by each FIFO and not yet seen on the output
    t_req_data rd_q[$];
    t_req_data wr_q[$];

    // Stream tags in the order they left the buffer
    t_chan chan_log[$];

    // Back-pressure level as the DUT saw it at the most recent rising edge
    logic oaf_at_edge = 1'b0;

    // 16-bit Fibonacci LFSR with taps at bits 16 14 13 11
    logic [15:0] lfsr_state = 16'd5;

    req_buffer_top
    #(
        .N_ENTRIES       (N_ENTRIES),
        .THRESHOLD       (THRESHOLD)
    )
    req_buffer_top_inst
    (
        .clk             (clk),
        .resetb          (resetb),
        .rd_enq_data     (rd_enq_data),
        .rd_enq_en       (rd_enq_en),
        .rd_not_full     (rd_not_full),
        .rd_almost_full  (rd_almost_full),
        .wr_enq_data     (wr_enq_data),
        .wr_enq_en       (wr_enq_en),
        .wr_not_full     (wr_not_full),
        .wr_almost_full  (wr_almost_full),
        .out_almost_full (out_almost_full),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_chan        (out_chan)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    // A full payload takes one LFSR step per bit
    function automatic t_req_data lfsr_word();
        t_req_data w;
        w = '0;
        for (int i = 0; i < REQ_DATA_BITS; i++)
        begin
            w = {w[REQ_DATA_BITS-2:0], lfsr_bit()};
        end
        return w;
    endfunction

    task automatic report_fail(input string what);
        $display("Fail at %0t ns: %s", $time, what);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on a mismatch");
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: %s", what);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on a timeout");
    endtask

    task automatic check_data(input t_req_data actual, input t_req_data expected,
                              input string what);
        if (actual !== expected)
        begin
            report_fail($sformatf("%s is %h, expected %h", what, actual, expected));
        end
    endtask

    task automatic check_chan(input t_chan actual, input t_chan expected, input string what);
        if (actual !== expected)
        begin
            report_fail($sformatf("%s is %s, expected %s", what, actual.name(), expected.name()));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            report_fail($sformatf("%s is %b, expected %b", what, actual, expected));
        end
    endtask

    always @(posedge clk)
    begin
        oaf_at_edge <= out_almost_full;
    end

    // Output monitor
    // Each output request must be the oldest one of the stream that its tag names
    initial
    begin
        t_req_data expected;
        forever
        begin
            @(negedge clk);
            // A high almost-full at an edge blocks the dequeue that would show up here
            if (oaf_at_edge)
            begin
                check_flag(out_valid, 1'b0, "out_valid after an almost-full cycle");
            end
            if (out_valid)
            begin
                chan_log.push_back(out_chan);
                if (out_chan == CHAN_RD)
                begin
                    if (rd_q.size() == 0)
                    begin
                        report_fail("read request on the output with none pending");
                    end
                    else
                    begin
                        expected = rd_q.pop_front();
                        check_data(out_data, expected, "read payload");
                    end
                end
                else
                begin
                    if (wr_q.size() == 0)
                    begin
                        report_fail("write request on the output with none pending");
                    end
                    else
                    begin
                        expected = wr_q.pop_front();
                        check_data(out_data, expected, "write payload");
                    end
                end
            end
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        resetb = 1'b0;
        repeat (4) @(negedge clk);
        resetb = 1'b1;
    endtask

    // Present one request per selected stream for a single cycle
    task automatic push_requests(input logic rd_go, input logic wr_go);
        @(negedge clk);
        rd_enq_en = rd_go;
        wr_enq_en = wr_go;
        if (rd_go)
        begin
            rd_enq_data = lfsr_word();
            rd_q.push_back(rd_enq_data);
        end
        if (wr_go)
        begin
            wr_enq_data = lfsr_word();
            wr_q.push_back(wr_enq_data);
        end
    endtask

    task automatic idle_producers();
        @(negedge clk);
        rd_enq_en = 1'b0;
        wr_enq_en = 1'b0;
    endtask

    task automatic wait_drained(input int limit, input string what);
        int cycles;
        cycles = 0;
        while (rd_q.size() != 0 || wr_q.size() != 0)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
            begin
                timed_out(what);
            end
        end
    endtask

    task automatic test_reset_state();
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(rd_not_full, 1'b1, "rd_not_full after reset");
        check_flag(wr_not_full, 1'b1, "wr_not_full after reset");
        check_flag(rd_almost_full, 1'b0, "rd_almost_full after reset");
        check_flag(wr_almost_full, 1'b0, "wr_almost_full after reset");
    endtask

    // Send one request through an idle buffer and count edges from its enqueue edge
    task automatic measure_latency(input t_chan chan);
        t_req_data sent;
        int        edges;
        push_requests(chan == CHAN_RD, chan == CHAN_WR);
        sent  = (chan == CHAN_RD) ? rd_enq_data : wr_enq_data;
        edges = 0;
        while (!out_valid)
        begin
            @(negedge clk);
            rd_enq_en = 1'b0;
            wr_enq_en = 1'b0;
            edges++;
            if (edges > 10)
            begin
                timed_out("single request never reached the output");
            end
        end
        if (edges != 2)
        begin
            report_fail($sformatf("%s request took %0d edges, expected 2", chan.name(), edges));
        end
        check_chan(out_chan, chan, "out_chan of single request");
        check_data(out_data, sent, "out_data of single request");
    endtask

    task automatic test_latency();
        measure_latency(CHAN_RD);
        measure_latency(CHAN_WR);
        wait_drained(10, "latency test left requests behind");
    endtask

    task automatic test_flags();
        @(negedge clk);
        out_almost_full = 1'b1;
        for (int held = 1; held <= N_ENTRIES; held++)
        begin
            push_requests(1'b1, 1'b0);
            idle_producers();
            // Warning once THRESHOLD or fewer slots remain free
            check_flag(rd_almost_full, (N_ENTRIES - held) <= THRESHOLD, "rd_almost_full");
            check_flag(rd_not_full, held != N_ENTRIES, "rd_not_full");
        end
        @(negedge clk);
        out_almost_full = 1'b0;
        wait_drained(4 * N_ENTRIES, "full read FIFO did not drain");
        @(negedge clk);
        check_flag(rd_not_full, 1'b1, "rd_not_full after drain");
        check_flag(rd_almost_full, 1'b0, "rd_almost_full after drain");
    endtask

    task automatic test_fairness();
        t_chan expected;
        // Start from reset so the read stream holds priority
        apply_reset();
        @(negedge clk);
        out_almost_full = 1'b1;
        for (int i = 0; i < 5; i++)
        begin
            push_requests(i < 3, 1'b1);
        end
        idle_producers();
        chan_log.delete();
        out_almost_full = 1'b0;
        wait_drained(40, "fairness requests did not drain");
        if (chan_log.size() != 8)
        begin
            report_fail($sformatf("%0d requests left the buffer, expected 8", chan_log.size()));
        end
        // Alternate while both streams wait, then the write stream runs alone
        for (int i = 0; i < 8; i++)
        begin
            expected = (i < 6 && (i % 2) == 0) ? CHAN_RD : CHAN_WR;
            check_chan(chan_log[i], expected, $sformatf("out_chan of grant %0d", i));
        end
    endtask

    task automatic test_random_traffic();
        logic rd_go;
        logic wr_go;
        logic flip_a;
        logic flip_b;
        for (int cyc = 0; cyc < 300; cyc++)
        begin
            @(negedge clk);
            rd_go  = lfsr_bit();
            wr_go  = lfsr_bit();
            flip_a = lfsr_bit();
            flip_b = lfsr_bit();
            // Producers stop on almost_full so a FIFO never overflows
            rd_enq_en = rd_go && !rd_almost_full;
            wr_enq_en = wr_go && !wr_almost_full;
            if (rd_enq_en)
            begin
                rd_enq_data = lfsr_word();
                rd_q.push_back(rd_enq_data);
            end
            if (wr_enq_en)
            begin
                wr_enq_data = lfsr_word();
                wr_q.push_back(wr_enq_data);
            end
            if (flip_a && flip_b)
            begin
                out_almost_full = !out_almost_full;
            end
        end
        idle_producers();
        out_almost_full = 1'b0;
        wait_drained(8 * N_ENTRIES, "random traffic did not drain");
    endtask

    initial
    begin
        resetb          = 1'b0;
        rd_enq_data     = '0;
        rd_enq_en       = 1'b0;
        wr_enq_data     = '0;
        wr_enq_en       = 1'b0;
        out_almost_full = 1'b0;
        apply_reset();
        test_reset_state();
        test_latency();
        test_flags();
        test_fairness();
        test_random_traffic();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
req_buffer_pkg.sv
req_fifo_lutram.sv
req_issue_arb.sv
req_buffer_top.sv
req_buffer_tb.sv

// File: Makefile
# Verilator build and run for the request buffer testbench
# Any variable below can be set on the command line, e.g. make test TOP=...

VERILATOR ?= verilator
TOP       ?= req_buffer_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

FILE_LIST := verilog.f
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR VFLAGS"

# The simulator exits with a failing status when the testbench stops on $fatal
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
